//--- hdl/l1d_pkg.sv
package l1d_pkg;

  // ========================================
  // Widths and address split
  // ========================================

  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 6;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_WORDS = 4;

  // Byte within a word, word within a line
  localparam int BYTE_SEL_W = $clog2(WORD_W / 8);
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);

  localparam logic [WORD_SEL_W-1:0] LAST_WORD = WORD_SEL_W'(LINE_WORDS - 1);

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  // Word 0 sits in the low bits of the line
  typedef word_t [LINE_WORDS-1:0] line_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // ========================================
  // Payloads
  // ========================================

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // Store data is right aligned, byte in [7:0] and half in [15:0]
  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    size_e size;
  } core_req_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    size_e size;
  } mem_req_t;

  function automatic tag_t addr_tag(input addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(input addr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [WORD_SEL_W-1:0] addr_word(input addr_t addr);
    return addr[BYTE_SEL_W +: WORD_SEL_W];
  endfunction

endpackage

//--- hdl/l1d_sram.sv
`timescale 1ns/1ps

module l1d_sram #(
  parameter int  DEPTH_W   = 6,
  parameter type payload_t = logic
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [DEPTH_W-1:0] index,
  input  logic               rd,
  input  logic               wr,
  input  payload_t           wdata,
  output payload_t           rdata
);

  payload_t mem [2**DEPTH_W];

  // Clearing every entry also clears the valid bits of the tag store
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**DEPTH_W; i++)
      begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end
    else
    begin
      if (wr)
      begin
        mem[index] <= wdata;
      end
      // Output holds between strobes
      if (rd)
      begin
        rdata <= mem[index];
      end
    end
  end

endmodule

//--- hdl/l1d_controller.sv
`timescale 1ns/1ps

module l1d_controller (
  input  logic                clk,
  input  logic                rst,
  input  logic                core_req,
  input  l1d_pkg::core_req_t  core_cmd,
  output logic                core_wait,
  output l1d_pkg::word_t      core_rdata,
  output logic                mem_req,
  output l1d_pkg::mem_req_t   mem_cmd,
  input  logic                mem_wait,
  input  l1d_pkg::word_t      mem_rdata,
  output l1d_pkg::index_t     store_index,
  output logic                store_rd,
  output logic                tag_wr,
  output l1d_pkg::tag_entry_t tag_wdata,
  input  l1d_pkg::tag_entry_t tag_rdata,
  output logic                line_wr,
  output l1d_pkg::line_t      line_wdata,
  input  l1d_pkg::line_t      line_rdata
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_RD_SEND,
    ST_RD_WAIT,
    ST_FILL,
    ST_WR_WAIT
  } state_e;

  state_e                                  state;
  state_e                                  state_next;
  l1d_pkg::core_req_t                      req_q;
  l1d_pkg::line_t                          line_buf;
  l1d_pkg::line_t                          line_merged;
  logic [l1d_pkg::WORD_SEL_W-1:0]          beat;
  logic [l1d_pkg::WORD_SEL_W-1:0]          req_word;
  logic                                    hit;
  logic                                    hit_q;
  logic                                    mem_done;

  // Place the right aligned store data into its byte lanes
  function automatic l1d_pkg::word_t merge_store(
    input l1d_pkg::word_t     old_word,
    input l1d_pkg::core_req_t req
  );
    l1d_pkg::word_t w;
    w = old_word;
    case (req.size)
      l1d_pkg::SIZE_BYTE: w[{req.addr[1:0], 3'b000} +: 8] = req.wdata[7:0];
      l1d_pkg::SIZE_HALF: w[{req.addr[1], 4'b0000} +: 16] = req.wdata[15:0];
      default:            w = req.wdata;
    endcase
    return w;
  endfunction

  // ========================================
  // Lookup
  // ========================================

  assign req_word = l1d_pkg::addr_word(req_q.addr);
  assign hit      = tag_rdata.valid && (tag_rdata.tag == l1d_pkg::addr_tag(req_q.addr));
  assign mem_done = !mem_wait;

  always_comb
  begin
    line_merged           = line_rdata;
    line_merged[req_word] = merge_store(line_rdata[req_word], req_q);
  end

  // ========================================
  // FSM
  // ========================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
      begin
        if (core_req)
        begin
          state_next = ST_LOOKUP;
        end
      end
      ST_LOOKUP:
      begin
        if (req_q.write)
        begin
          state_next = ST_WR_WAIT;
        end
        else if (hit)
        begin
          state_next = ST_IDLE;
        end
        else
        begin
          state_next = ST_RD_SEND;
        end
      end
      ST_RD_SEND:
      begin
        state_next = ST_RD_WAIT;
      end
      ST_RD_WAIT:
      begin
        if (mem_done)
        begin
          state_next = (beat == l1d_pkg::LAST_WORD) ? ST_FILL : ST_RD_SEND;
        end
      end
      ST_FILL:
      begin
        state_next = ST_IDLE;
      end
      ST_WR_WAIT:
      begin
        if (mem_done)
        begin
          state_next = ST_IDLE;
        end
      end
      default:
      begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ========================================
  // Datapath registers
  // ========================================

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && core_req)
    begin
      req_q <= core_cmd;
    end
  end

  // Shared by the refill beats and the merged store line
  always_ff @(posedge clk)
  begin
    if (state == ST_LOOKUP && req_q.write)
    begin
      line_buf <= line_merged;
    end
    else if (state == ST_RD_WAIT && mem_done)
    begin
      line_buf[beat] <= mem_rdata;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      beat       <= '0;
      hit_q      <= 1'b0;
      core_rdata <= '0;
    end
    else
    begin
      if (state == ST_LOOKUP)
      begin
        beat  <= '0;
        hit_q <= hit;
        if (!req_q.write && hit)
        begin
          core_rdata <= line_rdata[req_word];
        end
      end
      // Wraps back to zero after the last beat
      if (state == ST_RD_WAIT && mem_done)
      begin
        beat <= beat + 1'b1;
      end
      // Critical word out of the completed fill line
      if (state == ST_FILL)
      begin
        core_rdata <= line_buf[req_word];
      end
    end
  end

  // ========================================
  // Outputs
  // ========================================

  assign core_wait   = (state != ST_IDLE) || core_req;
  assign store_rd    = (state == ST_IDLE) && core_req;
  assign store_index = (state == ST_IDLE) ? l1d_pkg::addr_index(core_cmd.addr)
                                          : l1d_pkg::addr_index(req_q.addr);

  // Store goes out in the lookup cycle, refill beats from the send state
  assign mem_req = (state == ST_RD_SEND) || (state == ST_LOOKUP && req_q.write);

  always_comb
  begin
    mem_cmd.write = req_q.write;
    if (req_q.write)
    begin
      mem_cmd.addr  = req_q.addr;
      mem_cmd.wdata = req_q.wdata;
      mem_cmd.size  = req_q.size;
    end
    else
    begin
      mem_cmd.addr  = {req_q.addr[l1d_pkg::ADDR_W-1:l1d_pkg::OFFSET_W], beat,
                       {l1d_pkg::BYTE_SEL_W{1'b0}}};
      mem_cmd.wdata = '0;
      mem_cmd.size  = l1d_pkg::SIZE_WORD;
    end
  end

  assign tag_wr          = (state == ST_FILL);
  assign tag_wdata.valid = 1'b1;
  assign tag_wdata.tag   = l1d_pkg::addr_tag(req_q.addr);

  // Line written on a fill, or on a store hit once memory has taken the store
  assign line_wr    = (state == ST_FILL) || (state == ST_WR_WAIT && mem_done && hit_q);
  assign line_wdata = line_buf;

endmodule

//--- hdl/l1d_cache_top.sv
`timescale 1ns/1ps

module l1d_cache_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               core_req,
  input  l1d_pkg::core_req_t core_cmd,
  output logic               core_wait,
  output l1d_pkg::word_t     core_rdata,
  output logic               mem_req,
  output l1d_pkg::mem_req_t  mem_cmd,
  input  logic               mem_wait,
  input  l1d_pkg::word_t     mem_rdata
);

  l1d_pkg::index_t     store_index;
  logic                store_rd;
  logic                tag_wr;
  l1d_pkg::tag_entry_t tag_wdata;
  l1d_pkg::tag_entry_t tag_rdata;
  logic                line_wr;
  l1d_pkg::line_t      line_wdata;
  l1d_pkg::line_t      line_rdata;

  l1d_controller controller (
    .clk         (clk),
    .rst         (rst),
    .core_req    (core_req),
    .core_cmd    (core_cmd),
    .core_wait   (core_wait),
    .core_rdata  (core_rdata),
    .mem_req     (mem_req),
    .mem_cmd     (mem_cmd),
    .mem_wait    (mem_wait),
    .mem_rdata   (mem_rdata),
    .store_index (store_index),
    .store_rd    (store_rd),
    .tag_wr      (tag_wr),
    .tag_wdata   (tag_wdata),
    .tag_rdata   (tag_rdata),
    .line_wr     (line_wr),
    .line_wdata  (line_wdata),
    .line_rdata  (line_rdata)
  );

  // Both stores see the same index and read strobe
  l1d_sram #(
    .DEPTH_W   (l1d_pkg::INDEX_W),
    .payload_t (l1d_pkg::tag_entry_t)
  ) tag_store (
    .clk   (clk),
    .rst   (rst),
    .index (store_index),
    .rd    (store_rd),
    .wr    (tag_wr),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  l1d_sram #(
    .DEPTH_W   (l1d_pkg::INDEX_W),
    .payload_t (l1d_pkg::line_t)
  ) line_store (
    .clk   (clk),
    .rst   (rst),
    .index (store_index),
    .rd    (store_rd),
    .wr    (line_wr),
    .wdata (line_wdata),
    .rdata (line_rdata)
  );

endmodule

//--- test/l1d_cache_assertions.sv
`timescale 1ns/1ps

module l1d_cache_assertions (
  input logic clk,
  input logic rst,
  input logic core_wait,
  input logic mem_req
);

  // Memory request is a single cycle pulse
  assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else $error("mem_req stayed high for more than one cycle");

  // Memory only sees traffic while the core is held
  assert property (@(posedge clk) disable iff (rst) mem_req |-> core_wait)
    else $error("mem_req issued while core_wait was low");

  assert property (@(posedge clk) $fell(rst) |-> !core_wait && !mem_req)
    else $error("core_wait or mem_req high right after reset");

endmodule

bind l1d_cache_top l1d_cache_assertions l1d_cache_assertions_i (
  .clk       (clk),
  .rst       (rst),
  .core_wait (core_wait),
  .mem_req   (mem_req)
);

//--- test/l1d_cache_tb.sv
`timescale 1ns/1ps

module l1d_cache_tb;

  localparam int NUM_OPS     = 300;
  localparam int CYCLE_LIMIT = NUM_OPS * 30;

  // Operation kinds counted in the summary
  localparam int RD_HIT  = 0;
  localparam int RD_MISS = 1;
  localparam int ST_HIT  = 2;
  localparam int ST_MISS = 3;

  // Two tags over the same four lines keep hits and conflicts frequent
  localparam l1d_pkg::tag_t TAG_A = 22'h00a5c;
  localparam l1d_pkg::tag_t TAG_B = 22'h1f3b1;

  logic               clk = 1'b0;
  logic               rst;
  logic               core_req;
  l1d_pkg::core_req_t core_cmd;
  logic               core_wait;
  l1d_pkg::word_t     core_rdata;
  logic               mem_req;
  l1d_pkg::mem_req_t  mem_cmd;
  logic               mem_wait = 1'b0;
  l1d_pkg::word_t     mem_rdata = '0;

  logic [15:0]        lfsr = 16'd41;
  int                 cycles = 0;
  int                 checks = 0;
  int                 errors = 0;
  int                 op_num = 0;
  int                 cur_kind = 0;
  int                 kind_ops [4];
  int                 kind_errors [4];

  // Memory model keyed by aligned word address
  l1d_pkg::word_t     mem_model [l1d_pkg::addr_t];
  // Cache model
  logic               model_valid [2**l1d_pkg::INDEX_W];
  l1d_pkg::tag_t      model_tag [2**l1d_pkg::INDEX_W];
  l1d_pkg::mem_req_t  mem_log [$];
  logic [1:0]         wait_plan [4];
  logic               mem_busy = 1'b0;
  int                 wait_left = 0;

  l1d_cache_top l1d_cache_top_i (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_cmd   (core_cmd),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_wait   (mem_wait),
    .mem_rdata  (mem_rdata)
  );

  always #4 clk = ~clk;

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Untouched words hold a pattern of their own address
  function automatic l1d_pkg::word_t mem_read(input l1d_pkg::addr_t addr);
    l1d_pkg::addr_t wa;
    wa = {addr[31:2], 2'b00};
    if (mem_model.exists(wa))
    begin
      return mem_model[wa];
    end
    return (wa * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic l1d_pkg::word_t apply_store(input l1d_pkg::word_t old,
                                                 input l1d_pkg::addr_t addr,
                                                 input l1d_pkg::word_t data,
                                                 input l1d_pkg::size_e size);
    l1d_pkg::word_t mask;
    l1d_pkg::word_t lanes;
    int             sh;
    sh = 8 * int'(addr[1:0]);
    case (size)
      l1d_pkg::SIZE_BYTE:
      begin
        mask  = 32'hff << sh;
        lanes = {24'h0, data[7:0]} << sh;
      end
      l1d_pkg::SIZE_HALF:
      begin
        sh    = 16 * int'(addr[1]);
        mask  = 32'hffff << sh;
        lanes = {16'h0, data[15:0]} << sh;
      end
      default:
      begin
        mask  = '1;
        lanes = data;
      end
    endcase
    return (old & ~mask) | (lanes & mask);
  endfunction

  task automatic count_error();
    errors++;
    kind_errors[cur_kind]++;
  endtask

  task automatic report_problem(input string msg);
    $display("Op %0d: %s", op_num, msg);
    count_error();
  endtask

  task automatic check_word(input string name, input l1d_pkg::word_t got,
                            input l1d_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %s got 0x%h expected 0x%h (op %0d)", name, got, exp, op_num);
      count_error();
    end
  endtask

  task automatic check_mem_cmd(input string name, input l1d_pkg::mem_req_t got,
                               input l1d_pkg::mem_req_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %s got 0x%h expected 0x%h (op %0d)", name, got, exp, op_num);
      count_error();
    end
  endtask

  // Pulse core_req, then count the cycles core_wait stays high
  task automatic issue_request(input l1d_pkg::core_req_t cmd, output int busy_cycles);
    @(posedge clk);
    core_req <= 1'b1;
    core_cmd <= cmd;
    @(negedge clk);
    busy_cycles = core_wait ? 1 : 0;
    @(posedge clk);
    core_req <= 1'b0;
    @(negedge clk);
    while (core_wait)
    begin
      busy_cycles++;
      @(negedge clk);
    end
  endtask

  // ========================================
  // Memory side and timeout
  // ========================================

  always @(posedge clk)
  begin
    if (rst)
    begin
      mem_busy  = 1'b0;
      wait_left = 0;
      mem_wait  <= 1'b0;
    end
    else if (mem_busy)
    begin
      if (wait_left == 0)
      begin
        mem_busy = 1'b0;
      end
      else
      begin
        wait_left = wait_left - 1;
        if (wait_left == 0)
        begin
          mem_wait <= 1'b0;
        end
      end
    end
    else if (mem_req)
    begin
      mem_log.push_back(mem_cmd);
      wait_left = int'(wait_plan[mem_cmd.addr[3:2]]);
      mem_busy  = 1'b1;
      mem_wait  <= (wait_left != 0);
      mem_rdata <= mem_read(mem_cmd.addr);
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ========================================
  // Stimulus and checks
  // ========================================

  initial
  begin
    l1d_pkg::core_req_t cmd;
    l1d_pkg::mem_req_t  exp_cmd;
    l1d_pkg::addr_t     addr;
    l1d_pkg::tag_t      tag;
    l1d_pkg::index_t    idx;
    logic [31:0]        r;
    logic               hit;
    int                 busy;
    int                 log_start;
    int                 new_cmds;

    rst      <= 1'b1;
    core_req <= 1'b0;
    core_cmd <= '0;
    for (int i = 0; i < 4; i++)
    begin
      kind_ops[i]    = 0;
      kind_errors[i] = 0;
      wait_plan[i]   = 2'b00;
    end
    for (int i = 0; i < 2**l1d_pkg::INDEX_W; i++)
    begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);

    for (int n = 0; n < NUM_OPS; n++)
    begin
      op_num = n;
      draw_bits(1, r);
      cmd.write = r[0];
      draw_bits(1, r);
      tag = r[0] ? TAG_B : TAG_A;
      draw_bits(2, r);
      idx = {4'b0000, r[1:0]};
      draw_bits(4, r);
      addr = {tag, idx, r[3:0]};
      draw_bits(2, r);
      cmd.size = (r[1:0] == 2'd0) ? l1d_pkg::SIZE_BYTE :
                 (r[1:0] == 2'd1) ? l1d_pkg::SIZE_HALF : l1d_pkg::SIZE_WORD;
      draw_bits(32, r);
      cmd.wdata = r;
      for (int k = 0; k < 4; k++)
      begin
        draw_bits(2, r);
        wait_plan[k] = r[1:0];
      end
      // Stores are aligned to their size while reads take any byte
      if (cmd.write && cmd.size == l1d_pkg::SIZE_HALF)
      begin
        addr[0] = 1'b0;
      end
      else if (cmd.write && cmd.size == l1d_pkg::SIZE_WORD)
      begin
        addr[1:0] = 2'b00;
      end
      if (!cmd.write)
      begin
        cmd.size = l1d_pkg::SIZE_WORD;
      end
      cmd.addr = addr;
      hit = model_valid[idx] && (model_tag[idx] == tag);
      if (cmd.write)
      begin
        cur_kind = hit ? ST_HIT : ST_MISS;
      end
      else
      begin
        cur_kind = hit ? RD_HIT : RD_MISS;
      end
      kind_ops[cur_kind]++;
      log_start = mem_log.size();
      issue_request(cmd, busy);
      new_cmds = mem_log.size() - log_start;

      if (!cmd.write)
      begin
        if (hit)
        begin
          if (busy != 2)
          begin
            report_problem($sformatf("read hit at 0x%h kept core_wait high %0d cycles, not 2",
                                     addr, busy));
          end
          if (new_cmds != 0)
          begin
            report_problem($sformatf("read hit at 0x%h went to memory", addr));
          end
        end
        else if (new_cmds != 4)
        begin
          report_problem($sformatf("read miss at 0x%h sent %0d memory requests, not 4",
                                   addr, new_cmds));
        end
        else
        begin
          // Beats walk the line from its base in word steps
          for (int k = 0; k < 4; k++)
          begin
            exp_cmd.addr  = {addr[31:4], 4'h0} + 32'(4 * k);
            exp_cmd.write = 1'b0;
            exp_cmd.wdata = '0;
            exp_cmd.size  = l1d_pkg::SIZE_WORD;
            check_mem_cmd("mem_cmd", mem_log[log_start + k], exp_cmd);
          end
        end
        if (!hit)
        begin
          model_valid[idx] = 1'b1;
          model_tag[idx]   = tag;
        end
        check_word("core_rdata", core_rdata, mem_read(addr));
      end
      else
      begin
        if (new_cmds != 1)
        begin
          report_problem($sformatf("store at 0x%h sent %0d memory requests, not 1",
                                   addr, new_cmds));
        end
        else
        begin
          exp_cmd.addr  = addr;
          exp_cmd.write = 1'b1;
          exp_cmd.wdata = cmd.wdata;
          exp_cmd.size  = cmd.size;
          check_mem_cmd("mem_cmd", mem_log[log_start], exp_cmd);
        end
        // Stores only change the memory model
        mem_model[{addr[31:2], 2'b00}] = apply_store(mem_read(addr), addr, cmd.wdata,
                                                     cmd.size);
      end
    end

    $display("read hit   : %0d ops, %0d errors", kind_ops[RD_HIT], kind_errors[RD_HIT]);
    $display("read miss  : %0d ops, %0d errors", kind_ops[RD_MISS], kind_errors[RD_MISS]);
    $display("store hit  : %0d ops, %0d errors", kind_ops[ST_HIT], kind_errors[ST_HIT]);
    $display("store miss : %0d ops, %0d errors", kind_ops[ST_MISS], kind_errors[ST_MISS]);
    $display("Done: %0d ops, %0d checks, %0d errors", NUM_OPS, checks, errors);
    if (errors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/l1d_pkg.sv
hdl/l1d_sram.sv
hdl/l1d_controller.sv
hdl/l1d_cache_top.sv
test/l1d_cache_assertions.sv
test/l1d_cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module l1d_cache_tb \
  -f sim.f \
  -o l1d_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/l1d_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "Testbench reported a failure, see $LOG"
  exit 1
fi

echo "Testbench reported no failure"
exit 0
